// ==== hw/fr_pkg.sv ====
package fr_pkg;

    localparam int FR_INPUTS    = 8;
    localparam int FR_RULES     = 5;
    localparam int FR_RULE_W    = 3;
    localparam int FR_SAMPLE_W  = 16;
    localparam int FR_TERM_W    = 16;
    localparam int FR_SUM_W     = 19;
    localparam int FR_SQ_SHIFT  = 16;
    localparam int FR_W_SHIFT   = 16;
    localparam int FR_QUANT_DIV = 100;
    localparam int FR_LUT_DEPTH = 64;
    localparam int FR_LUT_AW    = 6;

    // derived datapath widths
    localparam int FR_STRENGTH_W = 16;
    localparam int FR_DIFF_W     = FR_SAMPLE_W + 1;
    localparam int FR_SQR_W      = 2 * FR_DIFF_W - FR_SQ_SHIFT;
    localparam int FR_PROD_W     = FR_SQR_W + FR_SAMPLE_W;
    localparam int FR_SCL_W      = FR_PROD_W - FR_W_SHIFT;

    localparam string FR_WEIGHT_FILE = "weights.hex";
    localparam string FR_LUT_FILE    = "exp_lut.hex";

    typedef logic signed [FR_SAMPLE_W-1:0] fr_sample_t;
    typedef fr_sample_t [FR_INPUTS-1:0] fr_sample_vec_t;

    // mean in the high half, spread coefficient in the low half
    typedef struct packed {
        logic signed [FR_SAMPLE_W-1:0] m;
        logic [FR_SAMPLE_W-1:0]        v;
    } fr_weight_t;

    typedef fr_weight_t [FR_INPUTS-1:0] fr_weight_vec_t;

    typedef logic [FR_INPUTS-1:0][FR_TERM_W-1:0] fr_term_vec_t;

    typedef struct packed {
        logic                 valid;
        logic [FR_RULE_W-1:0] rule;
    } fr_rule_req_t;

    typedef struct packed {
        logic                     valid;
        logic [FR_RULE_W-1:0]     rule;
        logic [FR_STRENGTH_W-1:0] strength;
    } fr_result_t;

endpackage

// ==== hw/fr_weight_rom.sv ====
module fr_weight_rom (
    input  logic                   clk,
    input  fr_pkg::fr_rule_req_t   req_in,
    output fr_pkg::fr_weight_vec_t weights,
    output fr_pkg::fr_rule_req_t   req_out
);
    import fr_pkg::*;

    // rule-major, one word per input
    logic [$bits(fr_weight_t)-1:0] mem [FR_RULES * FR_INPUTS];

    initial begin
        $readmemh(FR_WEIGHT_FILE, mem);
    end

    // whole row for the rule in one read
    always_ff @(posedge clk) begin
        req_out <= req_in;
        if (req_in.valid) begin
            for (int i = 0; i < FR_INPUTS; i++) begin
                weights[i] <= fr_weight_t'(mem[int'(req_in.rule) * FR_INPUTS + i]);
            end
        end
    end

endmodule

// ==== hw/fr_distance_array.sv ====
module fr_distance_array (
    input  logic                   clk,
    input  logic                   rst,
    input  fr_pkg::fr_sample_vec_t sample_hold,
    input  fr_pkg::fr_weight_vec_t weights,
    input  fr_pkg::fr_rule_req_t   req_in,
    output fr_pkg::fr_term_vec_t   terms,
    output fr_pkg::fr_rule_req_t   req_out
);
    import fr_pkg::*;

    logic signed [FR_DIFF_W-1:0] diff    [FR_INPUTS];
    logic [2*FR_DIFF_W-1:0]      sq_full [FR_INPUTS];
    logic [FR_SQR_W-1:0]         sq      [FR_INPUTS];
    logic [FR_SAMPLE_W-1:0]      v_d     [FR_INPUTS];
    logic [FR_PROD_W-1:0]        prod    [FR_INPUTS];
    logic [FR_SCL_W-1:0]         scaled  [FR_INPUTS];
    fr_rule_req_t                req_d;

    always_comb begin
        for (int i = 0; i < FR_INPUTS; i++) begin
            diff[i]    = $signed(sample_hold[i]) - $signed(weights[i].m);
            sq_full[i] = diff[i] * diff[i];
            prod[i]    = sq[i] * v_d[i];
            scaled[i]  = prod[i][FR_PROD_W-1:FR_W_SHIFT];
        end
    end

    // stage one squares, v follows one cycle behind m
    always_ff @(posedge clk) begin
        for (int i = 0; i < FR_INPUTS; i++) begin
            sq[i]  <= sq_full[i][2*FR_DIFF_W-1:FR_SQ_SHIFT];
            v_d[i] <= weights[i].v;
        end
    end

    // stage two weights and saturates
    always_ff @(posedge clk) begin
        for (int i = 0; i < FR_INPUTS; i++) begin
            if (|scaled[i][FR_SCL_W-1:FR_TERM_W]) begin
                terms[i] <= '1;
            end else begin
                terms[i] <= scaled[i][FR_TERM_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_d   <= '0;
            req_out <= '0;
        end else begin
            req_d   <= req_in;
            req_out <= req_d;
        end
    end

    // catches unloaded weights or samples reaching the tree
    a_terms_known: assert property (@(posedge clk) disable iff (rst)
        req_out.valid |-> !$isunknown(req_out) && !$isunknown(terms));

endmodule

// ==== hw/fr_adder_tree.sv ====
module fr_adder_tree (
    input  logic                        clk,
    input  logic                        rst,
    input  fr_pkg::fr_term_vec_t        terms,
    input  fr_pkg::fr_rule_req_t        req_in,
    output logic [fr_pkg::FR_SUM_W-1:0] sum,
    output fr_pkg::fr_rule_req_t        req_out
);
    import fr_pkg::*;

    logic [FR_TERM_W:0]   lvl1 [FR_INPUTS/2];
    logic [FR_TERM_W+1:0] lvl2 [FR_INPUTS/4];
    fr_rule_req_t         req_1;
    fr_rule_req_t         req_2;

    // 8 to 4
    always_ff @(posedge clk) begin
        for (int i = 0; i < FR_INPUTS / 2; i++) begin
            lvl1[i] <= {1'b0, terms[2*i]} + {1'b0, terms[2*i+1]};
        end
    end

    // 4 to 2
    always_ff @(posedge clk) begin
        for (int i = 0; i < FR_INPUTS / 4; i++) begin
            lvl2[i] <= {1'b0, lvl1[2*i]} + {1'b0, lvl1[2*i+1]};
        end
    end

    // 2 to 1
    always_ff @(posedge clk) begin
        sum <= {1'b0, lvl2[0]} + {1'b0, lvl2[1]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_1   <= '0;
            req_2   <= '0;
            req_out <= '0;
        end else begin
            req_1   <= req_in;
            req_2   <= req_1;
            req_out <= req_2;
        end
    end

endmodule

// ==== hw/fr_exp_lut.sv ====
module fr_exp_lut (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [fr_pkg::FR_SUM_W-1:0] sum,
    input  fr_pkg::fr_rule_req_t        req_in,
    output fr_pkg::fr_result_t          result
);
    import fr_pkg::*;

    logic [FR_SUM_W-1:0]      quot;
    logic [FR_LUT_AW-1:0]     idx;
    fr_rule_req_t             req_d;
    logic [FR_STRENGTH_W-1:0] lut [FR_LUT_DEPTH];

    // falling exponential, entry 0 is full scale
    initial begin
        $readmemh(FR_LUT_FILE, lut);
    end

    assign quot = sum / FR_SUM_W'(FR_QUANT_DIV);

    // large sums all land on the last entry
    always_ff @(posedge clk) begin
        if (quot > FR_SUM_W'(FR_LUT_DEPTH - 1)) begin
            idx <= FR_LUT_AW'(FR_LUT_DEPTH - 1);
        end else begin
            idx <= quot[FR_LUT_AW-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_d  <= '0;
            result <= '0;
        end else begin
            req_d           <= req_in;
            result.valid    <= req_d.valid;
            result.rule     <= req_d.rule;
            result.strength <= lut[idx];
        end
    end

    // a known index always lands inside the table
    a_idx_in_table: assert property (@(posedge clk) disable iff (rst)
        req_d.valid |-> !$isunknown(idx));

endmodule

// ==== hw/fr_rule_ctrl.sv ====
module fr_rule_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  fr_pkg::fr_sample_vec_t samples,
    input  fr_pkg::fr_result_t     result,
    output fr_pkg::fr_rule_req_t   req,
    output fr_pkg::fr_sample_vec_t sample_hold,
    output logic                   done
);
    import fr_pkg::*;

    logic                 accept;
    logic                 busy;
    logic                 issuing;
    logic [FR_RULE_W-1:0] issue_cnt;
    logic [FR_RULE_W-1:0] res_cnt;

    assign accept = start && !busy;

    // held for the whole pass
    always_ff @(posedge clk) begin
        if (accept) begin
            sample_hold <= samples;
        end
    end

    // one rule per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            issuing   <= 1'b0;
            issue_cnt <= '0;
            req       <= '0;
        end else begin
            req.valid <= issuing;
            req.rule  <= issue_cnt;
            if (accept) begin
                issuing   <= 1'b1;
                issue_cnt <= '0;
            end else if (issuing) begin
                if (issue_cnt == FR_RULE_W'(FR_RULES - 1)) begin
                    issuing <= 1'b0;
                end
                issue_cnt <= issue_cnt + 1'b1;
            end
        end
    end

    // pass ends when the last result comes back
    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            res_cnt <= '0;
        end else if (accept) begin
            busy    <= 1'b1;
            done    <= 1'b0;
            res_cnt <= '0;
        end else if (busy && result.valid) begin
            if (res_cnt == FR_RULE_W'(FR_RULES - 1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            res_cnt <= res_cnt + 1'b1;
        end
    end

    // a result beyond the last rule would push the count past FR_RULES
    a_res_cnt_range: assert property (@(posedge clk) disable iff (rst)
        result.valid |-> res_cnt < FR_RULE_W'(FR_RULES));

    a_req_only_busy: assert property (@(posedge clk) disable iff (rst)
        req.valid |-> busy);

endmodule

// ==== hw/fr_rule_engine.sv ====
module fr_rule_engine (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  fr_pkg::fr_sample_vec_t samples,
    output fr_pkg::fr_result_t     result,
    output logic                   done
);
    import fr_pkg::*;

    fr_rule_req_t        req_ctrl;
    fr_rule_req_t        req_rom;
    fr_rule_req_t        req_dist;
    fr_rule_req_t        req_sum;
    fr_sample_vec_t      sample_hold;
    fr_weight_vec_t      weights;
    fr_term_vec_t        terms;
    logic [FR_SUM_W-1:0] sum;

    fr_rule_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .samples     (samples),
        .result      (result),
        .req         (req_ctrl),
        .sample_hold (sample_hold),
        .done        (done)
    );

    fr_weight_rom u_weight_rom (
        .clk     (clk),
        .req_in  (req_ctrl),
        .weights (weights),
        .req_out (req_rom)
    );

    fr_distance_array u_distance (
        .clk         (clk),
        .rst         (rst),
        .sample_hold (sample_hold),
        .weights     (weights),
        .req_in      (req_rom),
        .terms       (terms),
        .req_out     (req_dist)
    );

    fr_adder_tree u_adder_tree (
        .clk     (clk),
        .rst     (rst),
        .terms   (terms),
        .req_in  (req_dist),
        .sum     (sum),
        .req_out (req_sum)
    );

    fr_exp_lut u_exp_lut (
        .clk    (clk),
        .rst    (rst),
        .sum    (sum),
        .req_in (req_sum),
        .result (result)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 50;

    // free running, period 100
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

// ==== testbench/tb_fr_rule_engine.sv ====
module tb_fr_rule_engine;
    import fr_pkg::*;

    localparam int NUM_PASSES   = 30;
    localparam int PASS_CYCLES  = 20;
    localparam int MAX_CYCLES   = NUM_PASSES * PASS_CYCLES + 200;
    localparam int DRIVE_DELAY  = 10;
    // rom 1 + distance 2 + tree 3 + exponent 2 + one issue cycle
    localparam int FIRST_RESULT = 9;

    logic           clk;
    logic           rst;
    logic           start;
    fr_sample_vec_t samples;
    fr_result_t     result;
    logic           done;

    logic [31:0] w_mem   [FR_RULES * FR_INPUTS];
    logic [15:0] lut_mem [64];
    logic [31:0] rng_state;
    int          cycle_count = 0;

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    fr_rule_engine u_fr_rule_engine (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .samples (samples),
        .result  (result),
        .done    (done)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // reference strength of one rule for one sample vector
    function automatic longint model_strength(input fr_sample_vec_t x, input int r);
        logic [31:0]        w;
        logic signed [15:0] m;
        longint             diff;
        longint             sq;
        longint             term;
        longint             sum;
        longint             idx;
        sum = 0;
        for (int i = 0; i < FR_INPUTS; i++) begin
            w    = w_mem[r * FR_INPUTS + i];
            m    = w[31:16];
            diff = longint'(x[i]) - longint'(m);
            sq   = (diff * diff) >> 16;
            term = (sq * longint'(w[15:0])) >> 16;
            if (term > 65535) begin
                term = 65535;
            end
            sum = sum + term;
        end
        idx = sum / 100;
        if (idx > 63) begin
            idx = 63;
        end
        return longint'(lut_mem[idx]);
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic random_vector(output fr_sample_vec_t vec);
        for (int i = 0; i < FR_INPUTS; i++) begin
            rng_state = xorshift32(rng_state);
            vec[i]    = rng_state[15:0];
        end
    endtask

    task automatic check_idle(input string name, input int cycles, input logic exp_done);
        repeat (cycles) begin
            next_cycle();
            check_value({name, " result idle"}, 0, result.valid);
            check_value({name, " done level"}, exp_done, done);
        end
    endtask

    // busy_at >= 0 pulses start again that many cycles into the pass
    task automatic run_pass(input string name, input fr_sample_vec_t vec, input int busy_at);
        fr_sample_vec_t other;
        int             k;
        int             seen;
        k       = 0;
        seen    = 0;
        start   = 1'b1;
        samples = vec;
        next_cycle();
        start = 1'b0;
        check_value({name, " done cleared"}, 0, done);
        while (seen < FR_RULES) begin
            if (k == busy_at) begin
                random_vector(other);
                start   = 1'b1;
                samples = other;
            end
            next_cycle();
            start = 1'b0;
            k++;
            if (result.valid) begin
                check_value({name, " arrival cycle"}, FIRST_RESULT + seen, k);
                check_value({name, " rule index"}, seen, result.rule);
                check_value({name, " strength"}, model_strength(vec, seen), result.strength);
                seen++;
            end
            check_value({name, " done during pass"}, 0, done);
        end
        next_cycle();
        check_value({name, " done after last"}, 1, done);
        check_value({name, " no extra result"}, 0, result.valid);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "watchdog expired");
        end
    end

    initial begin
        fr_sample_vec_t vec;
        rst       = 1'b1;
        start     = 1'b0;
        samples   = '0;
        rng_state = 32'hdb2d;
        $readmemh(FR_WEIGHT_FILE, w_mem);
        $readmemh(FR_LUT_FILE, lut_mem);
        repeat (5) begin
            next_cycle();
        end
        rst = 1'b0;
        check_idle("after reset", 4, 1'b0);

        for (int p = 0; p < NUM_PASSES; p++) begin
            random_vector(vec);
            if (p % 5 == 4) begin
                run_pass($sformatf("random pass %0d", p), vec, 3);
                check_idle($sformatf("after busy start %0d", p), 10, 1'b1);
            end else begin
                run_pass($sformatf("random pass %0d", p), vec, -1);
            end
        end

        // extremes push the distance terms and the sum clamp
        for (int i = 0; i < FR_INPUTS; i++) begin
            vec[i] = 16'sh7fff;
        end
        run_pass("all max", vec, -1);
        for (int i = 0; i < FR_INPUTS; i++) begin
            vec[i] = 16'sh8000;
        end
        run_pass("all min", vec, -1);

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== fr_rule_engine.f ====
hw/fr_pkg.sv
hw/fr_weight_rom.sv
hw/fr_distance_array.sv
hw/fr_adder_tree.sv
hw/fr_exp_lut.sv
hw/fr_rule_ctrl.sv
hw/fr_rule_engine.sv
testbench/tb_clock_gen.sv
testbench/tb_fr_rule_engine.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_fr_rule_engine -f fr_rule_engine.f \
    -o tb_fr_rule_engine || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/tb_fr_rule_engine 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "Simulation passed" && exit 0 || exit 1

// ==== weights.hex ====
// each word: mean m (signed) in bits 31:16, spread v in bits 15:0; rule-major, 8 inputs per rule
00000300
10000280
f0000340
20000300
e0000200
08000380
f8000300
04000240
00000080
c0000060
400000a0
e8000070
18000090
a0000050
60000080
d00000a0
80001000
7fff1200
00001800
c0000e00
40001400
e0001000
20000c00
00002000
8000ffff
00000040
30000060
d0000040
10000030
f0000050
50000040
b0000060
7fff0600
80000500
7fff0400
80000600
7fff0500
80000400
7fff0600
80000500

// ==== exp_lut.hex ====
// one 16-bit strength per line, 65535 * exp(-i/8), index 0 first
ffff
e1ea
c75f
aff1
9b45
8906
78ed
6ab7
5e2d
531c
4958
40ba
391f
3269
2c7c
2742
22a5
1e93
1afb
17d0
1503
128b
105e
0e71
0cbf
0b3f
09ed
08c2
07bb
06d2
0605
0550
04b0
0423
03a7
0339
02d8
0282
0237
01f4
01ba
0186
0158
012f
010c
00ec
00d1
00b8
00a2
008f
007f
0070
0063
0057
004d
0044
003c
0035
002f
0029
0024
0020
001c
0019
